// File: src/srio_req_pkg.sv
package srio_req_pkg;

    // Packet format and transaction types
    localparam logic [3:0] FTYPE_DOORBELL = 4'hA;
    localparam logic [3:0] FTYPE_NWRITE   = 4'h5;
    localparam logic [3:0] TTYPE_NWRITE   = 4'h4;
    localparam logic [1:0] REQ_PRIO       = 2'd1;

    // Doorbell info codes
    localparam logic [15:0] INFO_TARGET_READY = 16'h0100;
    localparam logic [15:0] INFO_TARGET_BUSY  = 16'h01FF;
    localparam logic [15:0] INFO_SELF_CHECK   = 16'h0101;
    localparam logic [15:0] INFO_INTEG_BASE   = 16'h0200;

    // Target 1 sits 1 MiB above target 0
    localparam int TARGET_STRIDE_SHIFT = 20;

    typedef enum logic [2:0] {
        IDLE,
        DB_REQ,
        DB_RESP,
        NWR,
        INTEG_DB_REQ,
        WAIT_ACK
    } ctrl_state_e;

    typedef enum logic [1:0] {
        REQ_SELF_DB,
        REQ_NWR,
        REQ_INTEG_DB
    } ireq_kind_e;

    typedef enum logic [1:0] {
        ERR_NONE          = 2'd0,
        ERR_DB_NO_RESP    = 2'd1,
        ERR_INTEG_NO_RESP = 2'd2
    } err_type_e;

endpackage

// File: src/user_data_fifo.sv
`timescale 1ns/1ps
module user_data_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic        log_clk,
    input  logic        log_rst,
    input  logic        wr_valid_i,
    input  logic [63:0] wr_data_i,
    input  logic [7:0]  wr_keep_i,
    input  logic        wr_last_i,
    input  logic        rd_pop_i,
    output logic        wr_ready_o,
    output logic [63:0] rd_data_o,
    output logic [7:0]  rd_keep_o,
    output logic        rd_last_o,
    output logic        rd_empty_o
);
    localparam int AW = $clog2(FIFO_DEPTH);

    logic [63:0] data_mem [FIFO_DEPTH];
    logic [7:0]  keep_mem [FIFO_DEPTH];
    logic        last_mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          push;

    assign full       = (count == FIFO_DEPTH[AW:0]);
    assign rd_empty_o = (count == '0);
    // A full FIFO still takes a beat when one leaves in the same cycle
    assign wr_ready_o = !full || rd_pop_i;
    assign push       = wr_valid_i && wr_ready_o;

    // Show-ahead read port
    assign rd_data_o = data_mem[rd_ptr];
    assign rd_keep_o = keep_mem[rd_ptr];
    assign rd_last_o = last_mem[rd_ptr];

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (rd_pop_i) rd_ptr <= rd_ptr + 1'b1;
            case ({push, rd_pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge log_clk) begin
        if (push) begin
            data_mem[wr_ptr] <= wr_data_i;
            keep_mem[wr_ptr] <= wr_keep_i;
            last_mem[wr_ptr] <= wr_last_i;
        end
    end

endmodule

// File: src/iresp_decoder.sv
`timescale 1ns/1ps
module iresp_decoder (
    input  logic        log_clk,
    input  logic        log_rst,
    input  logic [15:0] target_id_i,
    input  logic        iresp_tvalid_i,
    input  logic [63:0] iresp_tdata_i,
    input  logic [31:0] iresp_tuser_i,
    output logic        rsp_ready_o,
    output logic        rsp_busy_o,
    output logic        rsp_confirm_o,
    output logic        target_sel_o,
    output logic [15:0] integ_info_o
);
    import srio_req_pkg::*;

    logic [3:0]  rsp_ftype;
    logic [15:0] rsp_src_id;
    logic [15:0] rsp_info;
    logic        rsp_hit;

    assign rsp_ftype  = iresp_tdata_i[55:52];
    assign rsp_info   = iresp_tdata_i[31:16];
    assign rsp_src_id = iresp_tuser_i[31:16];

    // Only doorbells from the selected remote endpoint count
    assign rsp_hit = iresp_tvalid_i && (rsp_ftype == FTYPE_DOORBELL) &&
                     (rsp_src_id == target_id_i);

    assign rsp_ready_o   = rsp_hit && (rsp_info == INFO_TARGET_READY);
    assign rsp_busy_o    = rsp_hit && (rsp_info == INFO_TARGET_BUSY);
    assign rsp_confirm_o = rsp_hit && (rsp_info == integ_info_o);

    // Target 0 expects 0x0201, target 1 expects 0x0200
    assign integ_info_o = INFO_INTEG_BASE | {15'd0, !target_sel_o};

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            target_sel_o <= 1'b0;
        end else if (rsp_confirm_o) begin
            target_sel_o <= !target_sel_o;
        end
    end

endmodule

// File: src/ireq_builder.sv
`timescale 1ns/1ps
module ireq_builder (
    input  logic                     log_clk,
    input  logic                     log_rst,
    input  logic                     req_start_i,
    input  srio_req_pkg::ireq_kind_e req_kind_i,
    input  logic [15:0]              src_id_i,
    input  logic [15:0]              des_id_i,
    input  logic                     target_sel_i,
    input  logic [15:0]              integ_info_i,
    input  logic                     ireq_tready_i,
    input  logic [63:0]              fifo_data_i,
    input  logic [7:0]               fifo_keep_i,
    input  logic                     fifo_last_i,
    input  logic                     fifo_empty_i,
    output logic                     req_done_o,
    output logic                     fifo_pop_o,
    output logic                     ireq_tvalid_o,
    output logic [63:0]              ireq_tdata_o,
    output logic [7:0]               ireq_tkeep_o,
    output logic                     ireq_tlast_o,
    output logic [31:0]              ireq_tuser_o
);
    import srio_req_pkg::*;

    logic        slot_free;
    logic        nwr_start;
    logic        db_start;
    logic        nwr_active;
    logic        hdr_pending;
    logic        hdr_now;
    logic [15:0] db_info;
    logic [63:0] db_beat;
    logic [63:0] nwr_hdr;

    // Output register is empty or hands its beat over this cycle
    assign slot_free = !ireq_tvalid_o || ireq_tready_i;
    assign nwr_start = req_start_i && (req_kind_i == REQ_NWR);
    assign db_start  = req_start_i && (req_kind_i != REQ_NWR);
    assign hdr_now   = hdr_pending || nwr_start;

    assign db_info = (req_kind_i == REQ_INTEG_DB) ? integ_info_i : INFO_SELF_CHECK;

    // Doorbell: tid, ftype, rsvd, prio, crf, rsvd, info, rsvd
    assign db_beat = {8'h00, FTYPE_DOORBELL, 4'h0, 1'b0, REQ_PRIO, 1'b0, 12'h000,
                      db_info, 16'h0000};

    // NWRITE header, size comes from the descriptor beat
    assign nwr_hdr = {7'h00, target_sel_i, FTYPE_NWRITE, TTYPE_NWRITE, 1'b0, REQ_PRIO, 1'b0,
                      fifo_data_i[7:0], 2'b00, {33'd0, target_sel_i} << TARGET_STRIDE_SHIFT};

    assign fifo_pop_o   = (nwr_active || nwr_start) && slot_free && !fifo_empty_i;
    assign req_done_o   = ireq_tvalid_o && ireq_tready_i && ireq_tlast_o;
    assign ireq_tuser_o = {src_id_i, des_id_i};

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            nwr_active    <= 1'b0;
            hdr_pending   <= 1'b0;
            ireq_tvalid_o <= 1'b0;
            ireq_tlast_o  <= 1'b0;
        end else begin
            if (nwr_start) begin
                nwr_active  <= 1'b1;
                hdr_pending <= 1'b1;
            end
            if (fifo_pop_o) begin
                ireq_tvalid_o <= 1'b1;
                ireq_tlast_o  <= fifo_last_i;
                hdr_pending   <= 1'b0;
                nwr_active    <= !fifo_last_i;
            end else if (db_start) begin
                ireq_tvalid_o <= 1'b1;
                ireq_tlast_o  <= 1'b1;
            end else if (slot_free) begin
                ireq_tvalid_o <= 1'b0;
                ireq_tlast_o  <= 1'b0;
            end
        end
    end

    always_ff @(posedge log_clk) begin
        if (fifo_pop_o) begin
            ireq_tdata_o <= hdr_now ? nwr_hdr : fifo_data_i;
            ireq_tkeep_o <= hdr_now ? 8'hFF : fifo_keep_i;
        end else if (db_start) begin
            ireq_tdata_o <= db_beat;
            ireq_tkeep_o <= 8'hFF;
        end
    end

endmodule

// File: src/req_ctrl_fsm.sv
`timescale 1ns/1ps
module req_ctrl_fsm #(
    parameter int TIMEOUT_CYCLES = 1024
) (
    input  logic                     log_clk,
    input  logic                     log_rst,
    input  logic                     self_check_i,
    input  logic                     nwr_req_i,
    input  logic                     link_initialized_i,
    input  logic                     req_done_i,
    input  logic                     rsp_ready_i,
    input  logic                     rsp_busy_i,
    input  logic                     rsp_confirm_i,
    output logic                     req_start_o,
    output srio_req_pkg::ireq_kind_e req_kind_o,
    output logic                     rapidio_ready_o,
    output logic                     nwr_ready_o,
    output logic                     nwr_busy_o,
    output logic                     nwr_ack_done_o,
    output logic                     error_o,
    output srio_req_pkg::err_type_e  error_type_o
);
    import srio_req_pkg::*;

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    ctrl_state_e      state;
    ctrl_state_e      state_next;
    logic [CNT_W-1:0] wait_cnt;
    logic             wait_state;
    logic             cnt_expired;
    logic             db_timeout;
    logic             ack_timeout;

    assign wait_state  = (state == DB_RESP) || (state == WAIT_ACK);
    assign cnt_expired = (wait_cnt == CNT_W'(TIMEOUT_CYCLES));

    // A response arriving in the last cycle still wins over the timeout
    assign db_timeout  = (state == DB_RESP) && cnt_expired && !rsp_ready_i && !rsp_busy_i;
    assign ack_timeout = (state == WAIT_ACK) && cnt_expired && !rsp_confirm_i;

    assign error_o      = db_timeout || ack_timeout;
    assign error_type_o = db_timeout  ? ERR_DB_NO_RESP :
                          ack_timeout ? ERR_INTEG_NO_RESP : ERR_NONE;

    // Link is held busy while a request is on the wire
    assign rapidio_ready_o = !((state == DB_REQ) || (state == NWR) || (state == INTEG_DB_REQ));

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (link_initialized_i && self_check_i) begin
                    state_next = DB_REQ;
                end else if (link_initialized_i && nwr_req_i) begin
                    state_next = NWR;
                end
            end
            DB_REQ: if (req_done_i) state_next = DB_RESP;
            DB_RESP: begin
                if (rsp_ready_i || rsp_busy_i || db_timeout) begin
                    state_next = IDLE;
                end
            end
            NWR: if (req_done_i) state_next = INTEG_DB_REQ;
            INTEG_DB_REQ: if (req_done_i) state_next = WAIT_ACK;
            WAIT_ACK: if (rsp_confirm_i || ack_timeout) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            state          <= IDLE;
            wait_cnt       <= '0;
            req_start_o    <= 1'b0;
            req_kind_o     <= REQ_SELF_DB;
            nwr_ready_o    <= 1'b0;
            nwr_busy_o     <= 1'b0;
            nwr_ack_done_o <= 1'b0;
        end else begin
            state <= state_next;

            // Counter runs only while waiting for a response
            wait_cnt <= wait_state ? wait_cnt + 1'b1 : '0;

            req_start_o <= 1'b0;
            if (state == IDLE && state_next == DB_REQ) begin
                req_start_o <= 1'b1;
                req_kind_o  <= REQ_SELF_DB;
            end else if (state == IDLE && state_next == NWR) begin
                req_start_o <= 1'b1;
                req_kind_o  <= REQ_NWR;
            end else if (state == NWR && state_next == INTEG_DB_REQ) begin
                req_start_o <= 1'b1;
                req_kind_o  <= REQ_INTEG_DB;
            end

            if (state == DB_RESP && rsp_ready_i) begin
                nwr_ready_o <= 1'b1;
                nwr_busy_o  <= 1'b0;
            end else if (state == DB_RESP && rsp_busy_i) begin
                nwr_ready_o <= 1'b0;
                nwr_busy_o  <= 1'b1;
            end else if (error_o || (state == IDLE && state_next == NWR)) begin
                nwr_ready_o <= 1'b0;
            end

            nwr_ack_done_o <= (state == WAIT_ACK) && rsp_confirm_i;
        end
    end

endmodule

// File: src/db_req_top.sv
`timescale 1ns/1ps
module db_req_top #(
    parameter int TIMEOUT_CYCLES = 1024,
    parameter int FIFO_DEPTH     = 32
) (
    input  logic                    log_clk,
    input  logic                    log_rst,

    input  logic [15:0]             src_id_i,
    input  logic [15:0]             des_id_i,
    input  logic [15:0]             target_id_i,

    input  logic                    self_check_i,
    input  logic                    nwr_req_i,
    input  logic                    link_initialized_i,

    output logic                    rapidio_ready_o,
    output logic                    nwr_ready_o,
    output logic                    nwr_busy_o,
    output logic                    nwr_ack_done_o,
    output logic                    error_o,
    output srio_req_pkg::err_type_e error_type_o,

    // User payload stream
    input  logic                    user_tvalid_i,
    output logic                    user_tready_o,
    input  logic [63:0]             user_tdata_i,
    input  logic [7:0]              user_tkeep_i,
    input  logic                    user_tlast_i,

    // Request stream to the core
    output logic                    ireq_tvalid_o,
    input  logic                    ireq_tready_i,
    output logic [63:0]             ireq_tdata_o,
    output logic [7:0]              ireq_tkeep_o,
    output logic                    ireq_tlast_o,
    output logic [31:0]             ireq_tuser_o,

    // Response stream, always accepted
    input  logic                    iresp_tvalid_i,
    input  logic [63:0]             iresp_tdata_i,
    input  logic [31:0]             iresp_tuser_i
);
    import srio_req_pkg::*;

    logic        req_start;
    ireq_kind_e  req_kind;
    logic        req_done;
    logic        rsp_ready;
    logic        rsp_busy;
    logic        rsp_confirm;
    logic        target_sel;
    logic [15:0] integ_info;
    logic        fifo_pop;
    logic [63:0] fifo_data;
    logic [7:0]  fifo_keep;
    logic        fifo_last;
    logic        fifo_empty;

    req_ctrl_fsm #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) u_ctrl (
        .log_clk           (log_clk),
        .log_rst           (log_rst),
        .self_check_i      (self_check_i),
        .nwr_req_i         (nwr_req_i),
        .link_initialized_i(link_initialized_i),
        .req_done_i        (req_done),
        .rsp_ready_i       (rsp_ready),
        .rsp_busy_i        (rsp_busy),
        .rsp_confirm_i     (rsp_confirm),
        .req_start_o       (req_start),
        .req_kind_o        (req_kind),
        .rapidio_ready_o   (rapidio_ready_o),
        .nwr_ready_o       (nwr_ready_o),
        .nwr_busy_o        (nwr_busy_o),
        .nwr_ack_done_o    (nwr_ack_done_o),
        .error_o           (error_o),
        .error_type_o      (error_type_o)
    );

    ireq_builder u_build (
        .log_clk      (log_clk),
        .log_rst      (log_rst),
        .req_start_i  (req_start),
        .req_kind_i   (req_kind),
        .src_id_i     (src_id_i),
        .des_id_i     (des_id_i),
        .target_sel_i (target_sel),
        .integ_info_i (integ_info),
        .ireq_tready_i(ireq_tready_i),
        .fifo_data_i  (fifo_data),
        .fifo_keep_i  (fifo_keep),
        .fifo_last_i  (fifo_last),
        .fifo_empty_i (fifo_empty),
        .req_done_o   (req_done),
        .fifo_pop_o   (fifo_pop),
        .ireq_tvalid_o(ireq_tvalid_o),
        .ireq_tdata_o (ireq_tdata_o),
        .ireq_tkeep_o (ireq_tkeep_o),
        .ireq_tlast_o (ireq_tlast_o),
        .ireq_tuser_o (ireq_tuser_o)
    );

    user_data_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .log_clk   (log_clk),
        .log_rst   (log_rst),
        .wr_valid_i(user_tvalid_i),
        .wr_data_i (user_tdata_i),
        .wr_keep_i (user_tkeep_i),
        .wr_last_i (user_tlast_i),
        .rd_pop_i  (fifo_pop),
        .wr_ready_o(user_tready_o),
        .rd_data_o (fifo_data),
        .rd_keep_o (fifo_keep),
        .rd_last_o (fifo_last),
        .rd_empty_o(fifo_empty)
    );

    iresp_decoder u_resp (
        .log_clk       (log_clk),
        .log_rst       (log_rst),
        .target_id_i   (target_id_i),
        .iresp_tvalid_i(iresp_tvalid_i),
        .iresp_tdata_i (iresp_tdata_i),
        .iresp_tuser_i (iresp_tuser_i),
        .rsp_ready_o   (rsp_ready),
        .rsp_busy_o    (rsp_busy),
        .rsp_confirm_o (rsp_confirm),
        .target_sel_o  (target_sel),
        .integ_info_o  (integ_info)
    );

endmodule

// File: tests/db_req_sva.sv
`timescale 1ns/1ps
module db_req_sva (
    input  logic                      log_clk,
    input  logic                      log_rst,
    input  logic                      ireq_tvalid_i,
    input  logic                      ireq_tready_i,
    input  logic [63:0]               ireq_tdata_i,
    input  logic [7:0]                ireq_tkeep_i,
    input  logic                      ireq_tlast_i,
    input  logic [31:0]               ireq_tuser_i,
    input  logic                      rapidio_ready_i,
    input  logic                      nwr_ready_i,
    input  logic                      nwr_busy_i,
    input  logic                      nwr_ack_done_i,
    input  logic                      error_i,
    input  srio_req_pkg::err_type_e   error_type_i,
    input  srio_req_pkg::ctrl_state_e ctrl_state_i,
    input  logic                      target_sel_i
);
    import srio_req_pkg::*;

    int unsigned fail_count = 0;

    // A stalled beat keeps its contents until it transfers
    a_ireq_stable: assert property (
        @(posedge log_clk) disable iff (log_rst)
        ireq_tvalid_i && !ireq_tready_i |=> ireq_tvalid_i &&
            $stable({ireq_tdata_i, ireq_tkeep_i, ireq_tlast_i, ireq_tuser_i})
    ) else begin
        fail_count++;
        $error("ireq beat changed or was dropped while stalled");
    end

    a_error_typed: assert property (
        @(posedge log_clk) disable iff (log_rst)
        error_i |-> error_type_i != ERR_NONE
    ) else begin
        fail_count++;
        $error("error_o raised with type ERR_NONE");
    end

    // Outputs held quiet while reset is applied
    a_reset_quiet: assert property (
        @(posedge log_clk)
        log_rst |-> !ireq_tvalid_i && !ireq_tlast_i && !nwr_ready_i && !nwr_busy_i &&
            !nwr_ack_done_i && !error_i && error_type_i == ERR_NONE &&
            rapidio_ready_i && !target_sel_i
    ) else begin
        fail_count++;
        $error("control outputs active during reset");
    end

    a_ack_in_wait: assert property (
        @(posedge log_clk) disable iff (log_rst)
        $rose(nwr_ack_done_i) |-> $past(ctrl_state_i) == WAIT_ACK
    ) else begin
        fail_count++;
        $error("nwr_ack_done_o rose outside WAIT_ACK");
    end

endmodule

bind db_req_top db_req_sva u_sva (
    .log_clk        (log_clk),
    .log_rst        (log_rst),
    .ireq_tvalid_i  (ireq_tvalid_o),
    .ireq_tready_i  (ireq_tready_i),
    .ireq_tdata_i   (ireq_tdata_o),
    .ireq_tkeep_i   (ireq_tkeep_o),
    .ireq_tlast_i   (ireq_tlast_o),
    .ireq_tuser_i   (ireq_tuser_o),
    .rapidio_ready_i(rapidio_ready_o),
    .nwr_ready_i    (nwr_ready_o),
    .nwr_busy_i     (nwr_busy_o),
    .nwr_ack_done_i (nwr_ack_done_o),
    .error_i        (error_o),
    .error_type_i   (error_type_o),
    .ctrl_state_i   (u_ctrl.state),
    .target_sel_i   (target_sel)
);

// File: tests/tb_db_req.sv
`timescale 1ns/1ps
module tb_db_req;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int FIFO_DEPTH     = 32;
    localparam int CYCLE_LIMIT    = 6 * (TIMEOUT_CYCLES + 200);
    localparam int RESP_DELAY     = 3;
    localparam logic [15:0] SRC_ID    = 16'h00A1;
    localparam logic [15:0] DES_ID    = 16'h00B2;
    localparam logic [15:0] TARGET_ID = 16'h00B2;

    typedef enum {ANSWER_NONE, ANSWER_READY, ANSWER_BUSY, ANSWER_ECHO} answer_e;

    logic        log_clk;
    logic        log_rst;
    logic        self_check_i;
    logic        nwr_req_i;
    logic        link_initialized_i;
    logic        rapidio_ready_o;
    logic        nwr_ready_o;
    logic        nwr_busy_o;
    logic        nwr_ack_done_o;
    logic        error_o;
    logic [1:0]  error_type_o;
    logic        user_tvalid_i;
    logic        user_tready_o;
    logic [63:0] user_tdata_i;
    logic [7:0]  user_tkeep_i;
    logic        user_tlast_i;
    logic        ireq_tvalid_o;
    logic        ireq_tready_i;
    logic [63:0] ireq_tdata_o;
    logic [7:0]  ireq_tkeep_o;
    logic        ireq_tlast_o;
    logic [31:0] ireq_tuser_o;
    logic        iresp_tvalid_i;
    logic [63:0] iresp_tdata_i;
    logic [31:0] iresp_tuser_i;

    int unsigned cycle = 0;
    int unsigned errors = 0;
    string       test_name;
    logic [72:0] exp_q[$];
    logic        bp_pattern [512];
    logic        bp_en;
    answer_e     answer;
    int          resp_wait;
    logic [15:0] resp_info;
    logic        resp_sent;
    logic        in_packet;
    int unsigned db_cycle;
    int unsigned resp_cycle;
    logic [1:0]  exp_err;
    logic        err_seen;
    logic        ack_seen;

    db_req_top #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) dut (
        .log_clk           (log_clk),
        .log_rst           (log_rst),
        .src_id_i          (SRC_ID),
        .des_id_i          (DES_ID),
        .target_id_i       (TARGET_ID),
        .self_check_i      (self_check_i),
        .nwr_req_i         (nwr_req_i),
        .link_initialized_i(link_initialized_i),
        .rapidio_ready_o   (rapidio_ready_o),
        .nwr_ready_o       (nwr_ready_o),
        .nwr_busy_o        (nwr_busy_o),
        .nwr_ack_done_o    (nwr_ack_done_o),
        .error_o           (error_o),
        .error_type_o      (error_type_o),
        .user_tvalid_i     (user_tvalid_i),
        .user_tready_o     (user_tready_o),
        .user_tdata_i      (user_tdata_i),
        .user_tkeep_i      (user_tkeep_i),
        .user_tlast_i      (user_tlast_i),
        .ireq_tvalid_o     (ireq_tvalid_o),
        .ireq_tready_i     (ireq_tready_i),
        .ireq_tdata_o      (ireq_tdata_o),
        .ireq_tkeep_o      (ireq_tkeep_o),
        .ireq_tlast_o      (ireq_tlast_o),
        .ireq_tuser_o      (ireq_tuser_o),
        .iresp_tvalid_i    (iresp_tvalid_i),
        .iresp_tdata_i     (iresp_tdata_i),
        .iresp_tuser_i     (iresp_tuser_i)
    );

    initial begin
        log_clk = 1'b0;
        forever #5 log_clk = ~log_clk;
    end

    always @(posedge log_clk) begin
        cycle <= cycle + 1;
    end

    // NWRITE header holds tid, ftype, ttype, prio, size and a 34-bit address
    function automatic logic [63:0] nwr_header(logic sel, logic [7:0] size);
        logic [33:0] addr;
        addr = sel ? 34'h0_0010_0000 : 34'h0;
        return {7'h00, sel, 4'h5, 4'h4, 1'b0, 2'd1, 1'b0, size, 2'b00, addr};
    endfunction

    function automatic logic [63:0] doorbell_beat(logic [15:0] info);
        return {8'h00, 4'hA, 4'h0, 1'b0, 2'd1, 1'b0, 12'h000, info, 16'h0000};
    endfunction

    task automatic step();
        @(posedge log_clk);
        #1;
    endtask

    task automatic check_level(string what, logic exp_val, logic act_val);
        assert (act_val === exp_val) else begin
            errors++;
            $display("[FAIL] %s: %s expected %0b actual %0b", test_name, what, exp_val,
                     act_val);
        end
    endtask

    task automatic check_drained();
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: %0d expected ireq beats never arrived", test_name, exp_q.size());
        end
    endtask

    task automatic report_counts();
        $display("Error counts: checks %0d, assertions %0d", errors, dut.u_sva.fail_count);
    endtask

    // Scoreboard compare plus the target side of the doorbell exchange
    task automatic check_ireq_beat();
        logic [72:0] exp_beat;
        logic [72:0] act_beat;
        act_beat = {ireq_tlast_o, ireq_tkeep_o, ireq_tdata_o};
        if (exp_q.size() == 0) begin
            errors++;
            $display("%s: unexpected ireq beat %h", test_name, act_beat);
        end else begin
            exp_beat = exp_q.pop_front();
            assert (act_beat == exp_beat) else begin
                errors++;
                $display("[FAIL] %s: ireq beat expected %h actual %h", test_name, exp_beat,
                         act_beat);
            end
        end
        assert (ireq_tuser_o == {SRC_ID, DES_ID}) else begin
            errors++;
            $display("[FAIL] %s: tuser expected %h actual %h", test_name, {SRC_ID, DES_ID},
                     ireq_tuser_o);
        end
        if (!in_packet && ireq_tdata_o[55:52] == 4'hA) begin
            db_cycle = cycle;
            case (answer)
                ANSWER_READY: resp_info = 16'h0100;
                ANSWER_BUSY:  resp_info = 16'h01FF;
                default:      resp_info = ireq_tdata_o[31:16];
            endcase
            if (answer != ANSWER_NONE) begin
                resp_wait = RESP_DELAY;
            end
        end
        in_packet = !ireq_tlast_o;
    endtask

    // Ready pattern and target responses change 1 ns after the edge
    always @(posedge log_clk) begin
        #1;
        ireq_tready_i = bp_en ? bp_pattern[cycle % 512] : 1'b1;
        iresp_tvalid_i = 1'b0;
        if (resp_wait > 0) begin
            resp_wait = resp_wait - 1;
            if (resp_wait == 0) begin
                iresp_tvalid_i = 1'b1;
                iresp_tdata_i  = {8'h00, 4'hA, 20'h00000, resp_info, 16'h0000};
                iresp_tuser_i  = {TARGET_ID, SRC_ID};
                resp_sent      = 1'b1;
            end
        end
    end

    // Sample mid-cycle when all inputs and outputs have settled
    always @(negedge log_clk) begin
        if (!log_rst) begin
            if (ireq_tvalid_o) begin
                check_level("rapidio_ready_o", 1'b0, rapidio_ready_o);
            end
            if (ireq_tvalid_o && ireq_tready_i) begin
                check_ireq_beat();
            end
            if (iresp_tvalid_i) begin
                resp_cycle = cycle;
            end
            if (error_o) begin
                err_seen = 1'b1;
                assert (error_type_o == exp_err) else begin
                    errors++;
                    $display("[FAIL] %s: error type expected %0d actual %0d", test_name,
                             exp_err, error_type_o);
                end
                assert (cycle == db_cycle + TIMEOUT_CYCLES + 1) else begin
                    errors++;
                    $display("[FAIL] %s: error cycle expected %0d actual %0d", test_name,
                             db_cycle + TIMEOUT_CYCLES + 1, cycle);
                end
            end
            if (nwr_ack_done_o) begin
                ack_seen = 1'b1;
                assert (cycle == resp_cycle + 1) else begin
                    errors++;
                    $display("[FAIL] %s: ack cycle expected %0d actual %0d", test_name,
                             resp_cycle + 1, cycle);
                end
            end
        end
    end

    task automatic push_beat(logic [63:0] data, logic [7:0] keep, logic last);
        logic accepted;
        user_tvalid_i = 1'b1;
        user_tdata_i  = data;
        user_tkeep_i  = keep;
        user_tlast_i  = last;
        accepted      = 1'b0;
        while (!accepted) begin
            @(negedge log_clk);
            accepted = user_tready_o;
            step();
        end
    endtask

    task automatic self_check(answer_e mode);
        resp_sent = 1'b0;
        step();
        answer = mode;
        exp_q.push_back({1'b1, 8'hFF, doorbell_beat(16'h0101)});
        self_check_i = 1'b1;
        step();
        self_check_i = 1'b0;
    endtask

    task automatic wait_response();
        while (!resp_sent) begin
            @(negedge log_clk);
        end
        @(negedge log_clk);
    endtask

    // Descriptor, data beats, then the integration doorbell
    task automatic send_packet(int n_data, logic sel, logic [15:0] info, answer_e mode);
        logic [63:0] word;
        logic [7:0]  keep;
        logic [7:0]  size;
        step();
        answer   = mode;
        ack_seen = 1'b0;
        err_seen = 1'b0;
        size     = 8'(n_data * 8 - 1);
        exp_q.push_back({1'b0, 8'hFF, nwr_header(sel, size)});
        push_beat({56'h0, size}, 8'hFF, 1'b0);
        for (int i = 0; i < n_data; i++) begin
            word = {$urandom, $urandom};
            keep = 8'($urandom);
            exp_q.push_back({i == n_data - 1, keep, word});
            push_beat(word, keep, i == n_data - 1);
        end
        user_tvalid_i = 1'b0;
        exp_q.push_back({1'b1, 8'hFF, doorbell_beat(info)});
        nwr_req_i = 1'b1;
        step();
        nwr_req_i = 1'b0;
        while (!ack_seen && !err_seen) begin
            @(negedge log_clk);
        end
    endtask

    initial begin
        void'($urandom(6));
        foreach (bp_pattern[i]) begin
            bp_pattern[i] = ($urandom % 4) != 0;
        end
        self_check_i       = 1'b0;
        nwr_req_i          = 1'b0;
        link_initialized_i = 1'b1;
        user_tvalid_i      = 1'b0;
        user_tdata_i       = '0;
        user_tkeep_i       = '0;
        user_tlast_i       = 1'b0;
        ireq_tready_i      = 1'b1;
        iresp_tvalid_i     = 1'b0;
        iresp_tdata_i      = '0;
        iresp_tuser_i      = '0;
        answer             = ANSWER_NONE;
        resp_wait          = 0;
        resp_info          = '0;
        resp_sent          = 1'b0;
        in_packet          = 1'b0;
        bp_en              = 1'b0;
        db_cycle           = 0;
        resp_cycle         = 0;
        exp_err            = 2'd0;
        err_seen           = 1'b0;
        ack_seen           = 1'b0;
        test_name          = "reset";
        log_rst            = 1'b0;
        #1;
        log_rst = 1'b1;
        repeat (5) @(posedge log_clk);
        #1;
        log_rst = 1'b0;
        step();

        test_name = "self_check_ready";
        self_check(ANSWER_READY);
        wait_response();
        check_level("nwr_ready_o", 1'b1, nwr_ready_o);
        check_level("nwr_busy_o", 1'b0, nwr_busy_o);
        check_level("rapidio_ready_o", 1'b1, rapidio_ready_o);
        check_drained();

        test_name = "self_check_busy";
        self_check(ANSWER_BUSY);
        wait_response();
        check_level("nwr_busy_o", 1'b1, nwr_busy_o);
        check_level("nwr_ready_o", 1'b0, nwr_ready_o);
        check_level("rapidio_ready_o", 1'b1, rapidio_ready_o);
        check_drained();

        test_name = "self_check_no_answer";
        exp_err   = 2'd1;
        err_seen  = 1'b0;
        self_check(ANSWER_NONE);
        while (!err_seen) begin
            @(negedge log_clk);
        end
        check_drained();

        // Confirming target 0 moves the selection to target 1
        test_name = "nwrite_target0";
        exp_err   = 2'd0;
        bp_en     = 1'b1;
        send_packet(6, 1'b0, 16'h0201, ANSWER_ECHO);
        check_level("nwr_ack_done_o pulse", 1'b1, ack_seen);
        check_drained();

        test_name = "nwrite_target1_unconfirmed";
        exp_err   = 2'd2;
        send_packet(4, 1'b1, 16'h0200, ANSWER_NONE);
        check_level("error_o pulse", 1'b1, err_seen);
        check_drained();

        // Selection must still point at target 1
        test_name = "nwrite_target1_retry";
        exp_err   = 2'd0;
        send_packet(3, 1'b1, 16'h0200, ANSWER_ECHO);
        check_level("nwr_ack_done_o pulse", 1'b1, ack_seen);
        check_drained();

        bp_en = 1'b0;
        repeat (4) step();
        report_counts();
        if (errors == 0 && dut.u_sva.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycle >= CYCLE_LIMIT);
        $display("Timeout: run stopped after %0d cycles before all tests finished", cycle);
        report_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: src.f
src/srio_req_pkg.sv
src/user_data_fifo.sv
src/iresp_decoder.sv
src/ireq_builder.sv
src/req_ctrl_fsm.sv
src/db_req_top.sv
tests/db_req_sva.sv
tests/tb_db_req.sv

// File: Bender.yml
package:
  name: db_req

sources:
  - src/srio_req_pkg.sv
  - src/user_data_fifo.sv
  - src/iresp_decoder.sv
  - src/ireq_builder.sv
  - src/req_ctrl_fsm.sv
  - src/db_req_top.sv
  - target: test
    files:
      - tests/db_req_sva.sv
      - tests/tb_db_req.sv
